// File: build.f
+incdir+rtl
rtl/id_pkg.sv
rtl/id_decoder.sv
rtl/id_operand_fwd.sv
rtl/id_branch_unit.sv
rtl/id_ex_reg.sv
rtl/id_stage.sv
sim/id_stage_props.sv
sim/id_stage_tb.sv

// File: Bender.yml
package:
  name: id_stage

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/id_pkg.sv
      - rtl/id_decoder.sv
      - rtl/id_operand_fwd.sv
      - rtl/id_branch_unit.sv
      - rtl/id_ex_reg.sv
      - rtl/id_stage.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/id_stage_props.sv
      - sim/id_stage_tb.sv

// File: sim/id_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_cfg.svh"

module id_stage_tb;

  import id_pkg::*;

  localparam int N_TESTS = 5;
  localparam int MAX_OPS = 64;
  localparam int LIMIT   = 16 + N_TESTS * (MAX_OPS + 4) + 64;

  logic       clk;
  logic       rst_n_i;
  word_t      pc_i;
  word_t      inst_i;
  word_t      reg1_data_i;
  word_t      reg2_data_i;
  wb_fwd_t    ex_fwd_i;
  wb_fwd_t    mem_fwd_i;
  alu_op_e    ex_aluop_i;
  logic       reg1_read_o;
  reg_addr_t  reg1_addr_o;
  logic       reg2_read_o;
  reg_addr_t  reg2_addr_o;
  branch_t    branch_o;
  logic       stall_o;
  ex_bundle_t ex_o;

  // Register file model
  word_t rf [32];

  // Next cycle's later-stage state
  wb_fwd_t nx_ex_fwd;
  wb_fwd_t nx_mem_fwd;
  alu_op_e nx_ex_aluop;

  // Expected values for the instruction on the inputs
  logic       chk_en = 1'b0;
  ex_bundle_t exp_ex;
  branch_t    exp_br;
  logic       exp_stall;
  logic       exp_rd1;
  logic       exp_rd2;
  logic       held_en;
  ex_bundle_t held_ex;

  word_t lfsr;
  string cur_test;
  int    n_tests = 0;
  int    checks = 0;
  int    errors = 0;
  int    chk0;
  int    err0;
  int    cycles = 0;

  logic [4:0] f3r [11] = '{5'b00000, 5'b00010, 5'b00100, 5'b00101, 5'b01000, 5'b01001,
                           5'b01010, 5'b01011, 5'b01110, 5'b01111, 5'b10000};
  alu_op_e op3r [11] = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_NOR, ALU_AND,
                         ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA};
  logic [4:0] fsh [3] = '{5'b00001, 5'b01001, 5'b10001};
  alu_op_e    opsh [3] = '{ALU_SLL, ALU_SRL, ALU_SRA};
  logic [3:0] f12 [6] = '{4'b1000, 4'b1001, 4'b1010, 4'b1101, 4'b1110, 4'b1111};
  alu_op_e    op12 [6] = '{ALU_SLT, ALU_SLTU, ALU_ADD, ALU_AND, ALU_OR, ALU_XOR};
  logic [3:0] fmem [8] = '{4'b0000, 4'b0001, 4'b0010, 4'b1000, 4'b1001,
                           4'b0100, 4'b0101, 4'b0110};
  alu_op_e opmem [8] = '{ALU_LD_B, ALU_LD_H, ALU_LD_W, ALU_LD_BU, ALU_LD_HU,
                         ALU_ST_B, ALU_ST_H, ALU_ST_W};
  logic [5:0] br_op6 [9] = '{6'b010011, 6'b010100, 6'b010101, 6'b010110, 6'b010111,
                             6'b011000, 6'b011001, 6'b011010, 6'b011011};
  alu_op_e br_aop [9] = '{ALU_JIRL, ALU_B, ALU_BL, ALU_BEQ, ALU_BNE,
                          ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU};
  br_kind_e br_kind [9] = '{BR_JIRL, BR_B, BR_BL, BR_EQ, BR_NE,
                            BR_LT, BR_GE, BR_LTU, BR_GEU};

  id_stage i_id_stage (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .pc_i        (pc_i),
    .inst_i      (inst_i),
    .reg1_data_i (reg1_data_i),
    .reg2_data_i (reg2_data_i),
    .ex_fwd_i    (ex_fwd_i),
    .mem_fwd_i   (mem_fwd_i),
    .ex_aluop_i  (ex_aluop_i),
    .reg1_read_o (reg1_read_o),
    .reg1_addr_o (reg1_addr_o),
    .reg2_read_o (reg2_read_o),
    .reg2_addr_o (reg2_addr_o),
    .branch_o    (branch_o),
    .stall_o     (stall_o),
    .ex_o        (ex_o)
  );

  assign reg1_data_i = rf[reg1_addr_o];
  assign reg2_data_i = rf[reg2_addr_o];

  initial
  begin
    clk = 1'b0;
    forever
      #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= LIMIT)
    begin
      $display("Timeout: run did not finish within %0d cycles", LIMIT);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // Galois LFSR, one step per bit
  function automatic word_t rand_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic reg_addr_t rand_reg();
    word_t v;
    v = rand_bits(`ID_REG_AW);
    return v[`ID_REG_AW-1:0];
  endfunction

  function automatic word_t rand_pc();
    word_t v;
    v = rand_bits(30);
    return {v[29:0], 2'b00};
  endfunction

  function automatic word_t enc_3r(input logic [4:0] fn, input reg_addr_t rk,
                                   input reg_addr_t rj, input reg_addr_t rd);
    return {12'h001, fn, rk, rj, rd};
  endfunction

  function automatic word_t enc_mem(input logic [3:0] op4, input logic [11:0] si12,
                                    input reg_addr_t rj, input reg_addr_t rd);
    return {6'b001010, op4, si12, rj, rd};
  endfunction

  function automatic alu_sel_e sel_of(input alu_op_e op);
    case (op)
      ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU: return SEL_ARITH;
      ALU_AND, ALU_OR, ALU_XOR, ALU_NOR:   return SEL_LOGIC;
      ALU_SLL, ALU_SRL, ALU_SRA:           return SEL_SHIFT;
      default:                             return SEL_NOP;
    endcase
  endfunction

  function automatic word_t fwd_ref(input logic rd, input reg_addr_t a, input word_t imm,
                                    input wb_fwd_t exf, input wb_fwd_t memf);
    if (!rd)
      return imm;
    if (a == '0)
      return '0;
    if (exf.wreg && exf.waddr == a)
      return exf.wdata;
    if (memf.wreg && memf.waddr == a)
      return memf.wdata;
    return rf[a];
  endfunction

  function automatic logic stall_ref(input alu_op_e ex_op, input reg_addr_t ex_wa,
                                     input logic rd1, input reg_addr_t a1,
                                     input logic rd2, input reg_addr_t a2);
    logic ld;
    ld = ex_op inside {ALU_LD_B, ALU_LD_H, ALU_LD_W, ALU_LD_BU, ALU_LD_HU};
    return ld && ((rd1 && ex_wa == a1) || (rd2 && ex_wa == a2));
  endfunction

  function automatic branch_t branch_ref(input br_kind_e k, input word_t pc, input word_t inst,
                                         input word_t a, input word_t b);
    branch_t r;
    word_t   o16;
    word_t   o26;
    word_t   tgt;
    word_t   lnk;
    logic    t;
    o16 = {{(`ID_XLEN-18){inst[25]}}, inst[25:10], 2'b00};
    o26 = {{(`ID_XLEN-28){inst[9]}}, inst[9:0], inst[25:10], 2'b00};
    tgt = pc + o16;
    lnk = '0;
    t   = 1'b0;
    case (k)
      BR_JIRL:
      begin
        t   = 1'b1;
        tgt = a + o16;
        lnk = pc + word_t'(`ID_PC_STEP);
      end
      BR_B:
      begin
        t   = 1'b1;
        tgt = pc + o26;
      end
      BR_BL:
      begin
        t   = 1'b1;
        tgt = pc + o26;
        lnk = pc + word_t'(`ID_PC_STEP);
      end
      BR_EQ:   t = (a == b);
      BR_NE:   t = (a != b);
      BR_LT:   t = ($signed(a) < $signed(b));
      BR_GE:   t = ($signed(a) >= $signed(b));
      BR_LTU:  t = (a < b);
      BR_GEU:  t = (a >= b);
      default: t = 1'b0;
    endcase
    r.taken  = t;
    r.target = t ? tgt : '0;
    r.link   = t ? lnk : '0;
    return r;
  endfunction

  function automatic ex_bundle_t ex_ref(input word_t inst, input word_t pc, input alu_op_e aop,
                                        input alu_sel_e sel, input word_t op1, input word_t op2,
                                        input logic wr, input br_kind_e bk, input logic stl);
    ex_bundle_t e;
    e.valid  = (aop != ALU_NOP);
    e.aluop  = aop;
    e.alusel = sel;
    e.op1    = op1;
    e.op2    = op2;
    e.waddr  = (bk == BR_BL) ? reg_addr_t'(`ID_LINK_REG) : inst[4:0];
    e.wreg   = wr;
    e.pc     = pc;
    e.inst   = inst;
    // A stalled slot becomes a bubble
    if (stl)
    begin
      e.valid  = 1'b0;
      e.wreg   = 1'b0;
      e.aluop  = ALU_NOP;
      e.alusel = SEL_NOP;
    end
    return e;
  endfunction

  task automatic cmp_bundle(input string name, input ex_bundle_t want, input ex_bundle_t got);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("Error %s ex_o: expected %h actual %h", name, want, got);
    end
  endtask

  task automatic cmp_branch(input string name, input branch_t want, input branch_t got);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("Error %s branch_o: expected %h actual %h", name, want, got);
    end
  endtask

  task automatic cmp_bit(input string name, input logic want, input logic got);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("Error %s bit: expected %b actual %b", name, want, got);
    end
  endtask

  // Comb outputs before the edge, ex_o half a cycle after it
  initial
  begin
    held_en = 1'b0;
    forever
    begin
      @(posedge clk);
      held_en = chk_en;
      if (chk_en)
      begin
        cmp_branch(cur_test, exp_br, branch_o);
        cmp_bit(cur_test, exp_stall, stall_o);
        cmp_bit(cur_test, exp_rd1, reg1_read_o);
        cmp_bit(cur_test, exp_rd2, reg2_read_o);
        held_ex = exp_ex;
      end
      @(negedge clk);
      if (held_en)
        cmp_bundle(cur_test, held_ex, ex_o);
    end
  end

  task automatic issue(input word_t inst, input word_t pc, input alu_op_e aop,
                       input alu_sel_e sel, input logic rd1, input logic rd2,
                       input word_t imm, input logic wr, input br_kind_e bk);
    reg_addr_t a1;
    reg_addr_t a2;
    word_t     op1;
    word_t     op2;
    logic      stl;
    @(negedge clk);
    a1  = inst[9:5];
    a2  = (sel == SEL_LOAD_STORE || bk inside {BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU})
          ? inst[4:0] : inst[14:10];
    op1 = fwd_ref(rd1, a1, imm, nx_ex_fwd, nx_mem_fwd);
    op2 = fwd_ref(rd2, a2, imm, nx_ex_fwd, nx_mem_fwd);
    stl = stall_ref(nx_ex_aluop, nx_ex_fwd.waddr, rd1, a1, rd2, a2);
    pc_i       = pc;
    inst_i     = inst;
    ex_fwd_i   = nx_ex_fwd;
    mem_fwd_i  = nx_mem_fwd;
    ex_aluop_i = nx_ex_aluop;
    exp_ex     = ex_ref(inst, pc, aop, sel, op1, op2, wr, bk, stl);
    exp_br     = branch_ref(stl ? BR_NONE : bk, pc, inst, op1, op2);
    exp_stall  = stl;
    exp_rd1    = rd1;
    exp_rd2    = rd2;
    chk_en     = 1'b1;
  endtask

  task automatic issue_add(input reg_addr_t rj, input reg_addr_t rk, input reg_addr_t rd);
    issue(enc_3r(5'b00000, rk, rj, rd), rand_pc(), ALU_ADD, SEL_ARITH, 1'b1, 1'b1, '0, 1'b1,
          BR_NONE);
  endtask

  task automatic test_begin(input string name);
    cur_test = name;
    n_tests++;
    chk0 = checks;
    err0 = errors;
    nx_ex_fwd   = '0;
    nx_mem_fwd  = '0;
    nx_ex_aluop = ALU_NOP;
  endtask

  task automatic test_end();
    @(negedge clk);
    chk_en = 1'b0;
    @(negedge clk);
    $display("test %-8s %0d checks, %0d errors", cur_test, checks - chk0, errors - err0);
  endtask

  task automatic run_alu();
    reg_addr_t rj;
    reg_addr_t rk;
    reg_addr_t rd;
    word_t     pick;
    word_t     v;
    word_t     inst;
    int        k;
    for (int i = 0; i < 40; i++)
    begin
      rj   = rand_reg();
      rk   = rand_reg();
      rd   = rand_reg();
      pick = rand_bits(3);
      case (pick[2:0])
        3'd0, 3'd1:
        begin
          k = rand_bits(4) % 11;
          issue(enc_3r(f3r[k], rk, rj, rd), rand_pc(), op3r[k], sel_of(op3r[k]),
                1'b1, 1'b1, '0, 1'b1, BR_NONE);
        end
        3'd2:
        begin
          k = rand_bits(2) % 3;
          issue({12'h004, fsh[k], rk, rj, rd}, rand_pc(), opsh[k], SEL_SHIFT,
                1'b1, 1'b0, {27'b0, rk}, 1'b1, BR_NONE);
        end
        3'd3, 3'd4:
        begin
          k = rand_bits(3) % 6;
          v = rand_bits(12);
          issue({6'b000000, f12[k], v[11:0], rj, rd}, rand_pc(), op12[k], sel_of(op12[k]),
                1'b1, 1'b0, {20'b0, v[11:0]}, 1'b1, BR_NONE);
        end
        3'd5:
        begin
          v = rand_bits(20);
          if (rj[0])
            issue({7'b0001110, v[19:0], rd}, rand_pc(), ALU_PCADD, SEL_MOVE,
                  1'b0, 1'b0, {v[19:0], 12'b0}, 1'b1, BR_NONE);
          else
            issue({7'b0001010, v[19:0], rd}, rand_pc(), ALU_LUI, SEL_MOVE,
                  1'b0, 1'b0, {v[19:0], 12'b0}, 1'b1, BR_NONE);
        end
        default:
        begin
          // Unknown 3R function, unused major group, reserved memory op
          k = rand_bits(2) % 3;
          if (k == 0)
            inst = enc_3r(5'b11111, rk, rj, rd);
          else if (k == 1)
          begin
            inst = rand_bits(26);
            inst[31:26] = 6'b111111;
          end
          else
            inst = enc_mem(4'b0011, 12'h000, rj, rd);
          issue(inst, rand_pc(), ALU_NOP, SEL_NOP, 1'b0, 1'b0, '0, 1'b0, BR_NONE);
        end
      endcase
    end
  endtask

  task automatic run_fwd();
    word_t v;
    nx_ex_fwd  = '{wreg: 1'b1, waddr: 5'd0, wdata: 32'hdead_0001};
    nx_mem_fwd = '{wreg: 1'b1, waddr: 5'd0, wdata: 32'hdead_0002};
    issue_add(5'd0, 5'd0, 5'd4);
    nx_ex_fwd  = '{wreg: 1'b1, waddr: 5'd5, wdata: 32'h1234_5678};
    nx_mem_fwd = '{wreg: 1'b1, waddr: 5'd5, wdata: 32'h8765_4321};
    issue_add(5'd5, 5'd3, 5'd4);
    nx_ex_fwd  = '{wreg: 1'b1, waddr: 5'd9, wdata: 32'h0bad_f00d};
    nx_mem_fwd = '{wreg: 1'b1, waddr: 5'd7, wdata: 32'h5555_aaaa};
    issue_add(5'd2, 5'd7, 5'd4);
    nx_ex_fwd  = '{wreg: 1'b0, waddr: 5'd5, wdata: 32'h1111_1111};
    nx_mem_fwd = '{wreg: 1'b0, waddr: 5'd5, wdata: 32'h2222_2222};
    issue_add(5'd5, 5'd5, 5'd4);
    // Small address range so hits are frequent
    for (int i = 0; i < 24; i++)
    begin
      v = rand_bits(6);
      nx_ex_fwd.wreg   = v[0];
      nx_ex_fwd.waddr  = {3'b000, v[2:1]};
      nx_mem_fwd.wreg  = v[3];
      nx_mem_fwd.waddr = {3'b000, v[5:4]};
      nx_ex_fwd.wdata  = rand_bits(32);
      nx_mem_fwd.wdata = rand_bits(32);
      v = rand_bits(4);
      issue_add({3'b000, v[1:0]}, {3'b000, v[3:2]}, rand_reg());
    end
  endtask

  task automatic run_branch();
    reg_addr_t rj;
    reg_addr_t rd;
    word_t     a;
    word_t     off;
    word_t     pick;
    br_kind_e  k;
    for (int b = 0; b < 9; b++)
    begin
      for (int i = 0; i < 6; i++)
      begin
        rj   = rand_reg();
        rd   = rj ^ 5'd1;
        a    = rand_bits(32);
        pick = rand_bits(2);
        nx_ex_fwd  = '{wreg: 1'b1, waddr: rj, wdata: a};
        nx_mem_fwd = '{wreg: 1'b1, waddr: rd, wdata: rand_bits(32)};
        if (pick[1:0] == 2'd0)
          nx_mem_fwd.wdata = a;
        off = rand_bits(16);
        k   = br_kind[b];
        issue({br_op6[b], off[15:0], rj, rd}, rand_pc(), br_aop[b], SEL_JUMP,
              !(k inside {BR_B, BR_BL}), k inside {BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU},
              '0, k inside {BR_JIRL, BR_BL}, k);
      end
    end
  endtask

  task automatic run_mem();
    logic  st;
    word_t v;
    for (int i = 0; i < 16; i++)
    begin
      st = opmem[i % 8] inside {ALU_ST_B, ALU_ST_H, ALU_ST_W};
      v  = rand_bits(12);
      issue(enc_mem(fmem[i % 8], v[11:0], rand_reg(), rand_reg()), rand_pc(), opmem[i % 8],
            SEL_LOAD_STORE, 1'b1, st, '0, !st, BR_NONE);
    end
    // Load in EX writing r6
    nx_ex_aluop = ALU_LD_W;
    nx_ex_fwd   = '{wreg: 1'b1, waddr: 5'd6, wdata: 32'hc0ff_ee00};
    issue_add(5'd6, 5'd2, 5'd3);
    issue_add(5'd2, 5'd6, 5'd3);
    issue(enc_mem(4'b0110, 12'h010, 5'd2, 5'd6), rand_pc(), ALU_ST_W, SEL_LOAD_STORE,
          1'b1, 1'b1, '0, 1'b0, BR_NONE);
    // Jumps on the loaded register must not redirect
    issue({6'b010011, 16'h0040, 5'd6, 5'd1}, rand_pc(), ALU_JIRL, SEL_JUMP,
          1'b1, 1'b0, '0, 1'b1, BR_JIRL);
    issue({6'b010111, 16'h0008, 5'd2, 5'd6}, rand_pc(), ALU_BNE, SEL_JUMP,
          1'b1, 1'b1, '0, 1'b0, BR_NE);
    nx_ex_aluop = ALU_LD_BU;
    issue(enc_mem(4'b0010, 12'h004, 5'd6, 5'd8), rand_pc(), ALU_LD_W, SEL_LOAD_STORE,
          1'b1, 1'b0, '0, 1'b1, BR_NONE);
    // Shift amount field equals r6 but is no register read
    issue({12'h004, 5'b00001, 5'd6, 5'd2, 5'd3}, rand_pc(), ALU_SLL, SEL_SHIFT,
          1'b1, 1'b0, 32'd6, 1'b1, BR_NONE);
    nx_ex_aluop = ALU_ST_W;
    issue_add(5'd6, 5'd6, 5'd3);
    nx_ex_aluop = ALU_LD_H;
    nx_ex_fwd   = '{wreg: 1'b1, waddr: 5'd9, wdata: 32'h0000_0099};
    issue_add(5'd6, 5'd7, 5'd3);
  endtask

  initial
  begin
    int total_err;
    lfsr        = 32'hd799;
    rst_n_i     = 1'b0;
    pc_i        = '0;
    inst_i      = '0;
    ex_fwd_i    = '0;
    mem_fwd_i   = '0;
    ex_aluop_i  = ALU_NOP;
    nx_ex_fwd   = '0;
    nx_mem_fwd  = '0;
    nx_ex_aluop = ALU_NOP;
    for (int r = 0; r < 32; r++)
      rf[r] = rand_bits(32);

    test_begin("reset");
    repeat (16) @(posedge clk);
    @(negedge clk);
    cmp_bit("reset", 1'b0, ex_o.valid);
    cmp_bit("reset", 1'b0, ex_o.wreg);
    rst_n_i = 1'b1;
    test_end();

    test_begin("alu");
    run_alu();
    test_end();
    test_begin("forward");
    run_fwd();
    test_end();
    test_begin("branch");
    run_branch();
    test_end();
    test_begin("memory");
    run_mem();
    test_end();

    total_err = errors + i_id_stage.u_props.fail_count;
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             n_tests, checks, errors, i_id_stage.u_props.fail_count);
    if (total_err == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/id_stage_props.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_props (
  input logic               clk,
  input logic               rst_n_i,
  input logic               stall_i,
  input id_pkg::branch_t    branch_i,
  input id_pkg::ex_bundle_t ex_i
);

  int fail_count = 0;

  // Stalled slot leaves as a bubble
  a_stall_bubble: assert property (@(posedge clk) disable iff (!rst_n_i)
                                   stall_i |=> !ex_i.valid)
    else
    begin
      fail_count++;
      $error("stall not followed by an invalid ex_o");
    end

  a_reset_clears: assert property (@(posedge clk) !rst_n_i |=> (!ex_i.valid && !ex_i.wreg))
    else
    begin
      fail_count++;
      $error("ex_o valid or wreg set after reset");
    end

  // Load-use operands are stale, so no redirect
  a_no_branch_on_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
                                         stall_i |-> !branch_i.taken)
    else
    begin
      fail_count++;
      $error("branch taken while a load-use stall is raised");
    end

endmodule

bind id_stage id_stage_props u_props (
  .clk      (clk),
  .rst_n_i  (rst_n_i),
  .stall_i  (stall_o),
  .branch_i (branch_o),
  .ex_i     (ex_o)
);

`default_nettype wire

// File: rtl/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_cfg.svh"

module id_stage (
  input  logic               clk,
  input  logic               rst_n_i,
  input  id_pkg::word_t      pc_i,
  input  id_pkg::word_t      inst_i,
  input  id_pkg::word_t      reg1_data_i,
  input  id_pkg::word_t      reg2_data_i,
  input  id_pkg::wb_fwd_t    ex_fwd_i,
  input  id_pkg::wb_fwd_t    mem_fwd_i,
  input  id_pkg::alu_op_e    ex_aluop_i,
  output logic               reg1_read_o,
  output id_pkg::reg_addr_t  reg1_addr_o,
  output logic               reg2_read_o,
  output id_pkg::reg_addr_t  reg2_addr_o,
  output id_pkg::branch_t    branch_o,
  output logic               stall_o,
  output id_pkg::ex_bundle_t ex_o
);

  import id_pkg::*;

  word_t      dec_imm;
  alu_op_e    dec_aluop;
  alu_sel_e   dec_alusel;
  reg_addr_t  dec_waddr;
  logic       dec_wreg;
  logic       dec_valid;
  br_kind_e   dec_br_kind;
  br_kind_e   br_kind;
  word_t      op1;
  word_t      op2;
  reg_addr_t  waddr;
  ex_bundle_t ex_next;

  id_decoder u_decoder (
    .inst_i      (inst_i),
    .ex_aluop_i  (ex_aluop_i),
    .ex_waddr_i  (ex_fwd_i.waddr),
    .reg1_read_o (reg1_read_o),
    .reg2_read_o (reg2_read_o),
    .reg1_addr_o (reg1_addr_o),
    .reg2_addr_o (reg2_addr_o),
    .imm_o       (dec_imm),
    .aluop_o     (dec_aluop),
    .alusel_o    (dec_alusel),
    .waddr_o     (dec_waddr),
    .wreg_o      (dec_wreg),
    .valid_o     (dec_valid),
    .br_kind_o   (dec_br_kind),
    .stall_o     (stall_o)
  );

  id_operand_fwd u_fwd1 (
    .read_i    (reg1_read_o),
    .addr_i    (reg1_addr_o),
    .rf_data_i (reg1_data_i),
    .imm_i     (dec_imm),
    .ex_fwd_i  (ex_fwd_i),
    .mem_fwd_i (mem_fwd_i),
    .operand_o (op1)
  );

  id_operand_fwd u_fwd2 (
    .read_i    (reg2_read_o),
    .addr_i    (reg2_addr_o),
    .rf_data_i (reg2_data_i),
    .imm_i     (dec_imm),
    .ex_fwd_i  (ex_fwd_i),
    .mem_fwd_i (mem_fwd_i),
    .operand_o (op2)
  );

  // Operands are stale under a load-use stall, so no redirect
  assign br_kind = stall_o ? BR_NONE : dec_br_kind;

  id_branch_unit u_branch (
    .kind_i   (br_kind),
    .pc_i     (pc_i),
    .inst_i   (inst_i),
    .op1_i    (op1),
    .op2_i    (op2),
    .branch_o (branch_o)
  );

  // BL links into the fixed return register
  assign waddr = (dec_br_kind == BR_BL) ? reg_addr_t'(`ID_LINK_REG) : dec_waddr;

  assign ex_next = '{valid: dec_valid, aluop: dec_aluop, alusel: dec_alusel, op1: op1,
                     op2: op2, waddr: waddr, wreg: dec_wreg, pc: pc_i, inst: inst_i};

  id_ex_reg u_id_ex_reg (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .stall_i (stall_o),
    .next_i  (ex_next),
    .ex_o    (ex_o)
  );

endmodule

`default_nettype wire

// File: rtl/id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 stall_i,
  input  id_pkg::ex_bundle_t   next_i,
  output id_pkg::ex_bundle_t   ex_o
);

  import id_pkg::*;

  logic      valid_q;
  logic      wreg_q;
  alu_op_e   aluop_q;
  alu_sel_e  alusel_q;
  word_t     op1_q;
  word_t     op2_q;
  reg_addr_t waddr_q;
  word_t     pc_q;
  word_t     inst_q;

  // Stall turns the slot into a bubble
  always_ff @(posedge clk)
  begin
    if (!rst_n_i || stall_i)
    begin
      valid_q  <= 1'b0;
      wreg_q   <= 1'b0;
      aluop_q  <= ALU_NOP;
      alusel_q <= SEL_NOP;
    end
    else
    begin
      valid_q  <= next_i.valid;
      wreg_q   <= next_i.wreg;
      aluop_q  <= next_i.aluop;
      alusel_q <= next_i.alusel;
    end
  end

  always_ff @(posedge clk)
  begin
    op1_q   <= next_i.op1;
    op2_q   <= next_i.op2;
    waddr_q <= next_i.waddr;
    pc_q    <= next_i.pc;
    inst_q  <= next_i.inst;
  end

  assign ex_o = '{valid: valid_q, aluop: aluop_q, alusel: alusel_q, op1: op1_q,
                  op2: op2_q, waddr: waddr_q, wreg: wreg_q, pc: pc_q, inst: inst_q};

endmodule

`default_nettype wire

// File: rtl/id_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_cfg.svh"

module id_branch_unit (
  input  id_pkg::br_kind_e kind_i,
  input  id_pkg::word_t    pc_i,
  input  id_pkg::word_t    inst_i,
  input  id_pkg::word_t    op1_i,
  input  id_pkg::word_t    op2_i,
  output id_pkg::branch_t  branch_o
);

  import id_pkg::*;

  word_t off16;
  word_t off26;
  word_t pc_link;
  word_t target;
  word_t link;
  logic  taken;
  logic  lt_s;
  logic  lt_u;

  assign off16   = {{(`ID_XLEN-18){inst_i[25]}}, inst_i[25:10], 2'b00};
  assign off26   = {{(`ID_XLEN-28){inst_i[9]}}, inst_i[9:0], inst_i[25:10], 2'b00};
  assign pc_link = pc_i + word_t'(`ID_PC_STEP);
  assign lt_s    = $signed(op1_i) < $signed(op2_i);
  assign lt_u    = op1_i < op2_i;

  always_comb
  begin
    taken  = 1'b0;
    target = pc_i + off16;
    link   = '0;
    case (kind_i)
      BR_JIRL:
      begin
        taken  = 1'b1;
        target = op1_i + off16;
        link   = pc_link;
      end
      BR_B:
      begin
        taken  = 1'b1;
        target = pc_i + off26;
      end
      BR_BL:
      begin
        taken  = 1'b1;
        target = pc_i + off26;
        link   = pc_link;
      end
      BR_EQ:   taken = (op1_i == op2_i);
      BR_NE:   taken = (op1_i != op2_i);
      BR_LT:   taken = lt_s;
      BR_GE:   taken = !lt_s;
      BR_LTU:  taken = lt_u;
      BR_GEU:  taken = !lt_u;
      default: taken = 1'b0;
    endcase
  end

  assign branch_o.taken  = taken;
  assign branch_o.target = taken ? target : '0;
  assign branch_o.link   = taken ? link : '0;

endmodule

`default_nettype wire

// File: rtl/id_operand_fwd.sv
`timescale 1ns/1ps
`default_nettype none

module id_operand_fwd (
  input  logic              read_i,
  input  id_pkg::reg_addr_t addr_i,
  input  id_pkg::word_t     rf_data_i,
  input  id_pkg::word_t     imm_i,
  input  id_pkg::wb_fwd_t   ex_fwd_i,
  input  id_pkg::wb_fwd_t   mem_fwd_i,
  output id_pkg::word_t     operand_o
);

  logic ex_hit;
  logic mem_hit;

  assign ex_hit  = ex_fwd_i.wreg && (ex_fwd_i.waddr == addr_i);
  assign mem_hit = mem_fwd_i.wreg && (mem_fwd_i.waddr == addr_i);

  // Youngest producer wins
  always_comb
  begin
    if (read_i && addr_i == '0)
      operand_o = '0;
    else if (read_i && ex_hit)
      operand_o = ex_fwd_i.wdata;
    else if (read_i && mem_hit)
      operand_o = mem_fwd_i.wdata;
    else if (read_i)
      operand_o = rf_data_i;
    else
      operand_o = imm_i;
  end

endmodule

`default_nettype wire

// File: rtl/id_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_cfg.svh"

module id_decoder (
  input  id_pkg::word_t     inst_i,
  input  id_pkg::alu_op_e   ex_aluop_i,
  input  id_pkg::reg_addr_t ex_waddr_i,
  output logic              reg1_read_o,
  output logic              reg2_read_o,
  output id_pkg::reg_addr_t reg1_addr_o,
  output id_pkg::reg_addr_t reg2_addr_o,
  output id_pkg::word_t     imm_o,
  output id_pkg::alu_op_e   aluop_o,
  output id_pkg::alu_sel_e  alusel_o,
  output id_pkg::reg_addr_t waddr_o,
  output logic              wreg_o,
  output logic              valid_o,
  output id_pkg::br_kind_e  br_kind_o,
  output logic              stall_o
);

  import id_pkg::*;

  localparam logic [6:0] OP7_LU12I     = 7'b0001010;
  localparam logic [6:0] OP7_PCADDU12I = 7'b0001110;

  major_op_e major;
  reg_addr_t rd;
  reg_addr_t rj;
  reg_addr_t rk;
  word_t     imm_u20;
  logic      ex_is_load;

  assign major   = major_op_e'(inst_i[31:26]);
  assign rd      = inst_i[4:0];
  assign rj      = inst_i[9:5];
  assign rk      = inst_i[14:10];
  assign imm_u20 = {inst_i[24:5], 12'b0};

  always_comb
  begin
    reg1_read_o = 1'b0;
    reg2_read_o = 1'b0;
    reg1_addr_o = rj;
    reg2_addr_o = rk;
    waddr_o     = rd;
    imm_o       = '0;
    aluop_o     = ALU_NOP;
    alusel_o    = SEL_NOP;
    wreg_o      = 1'b0;
    valid_o     = 1'b0;
    br_kind_o   = BR_NONE;

    case (major)
      OP_JIRL:
      begin
        valid_o     = 1'b1;
        wreg_o      = 1'b1;
        aluop_o     = ALU_JIRL;
        alusel_o    = SEL_JUMP;
        reg1_read_o = 1'b1;
        br_kind_o   = BR_JIRL;
      end
      OP_B, OP_BL:
      begin
        valid_o   = 1'b1;
        alusel_o  = SEL_JUMP;
        wreg_o    = (major == OP_BL);
        aluop_o   = (major == OP_BL) ? ALU_BL : ALU_B;
        br_kind_o = (major == OP_BL) ? BR_BL : BR_B;
      end
      OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:
      begin
        // Conditional branches compare rj against rd
        valid_o     = 1'b1;
        alusel_o    = SEL_JUMP;
        reg1_read_o = 1'b1;
        reg2_read_o = 1'b1;
        reg2_addr_o = rd;
        case (major)
          OP_BEQ:  begin aluop_o = ALU_BEQ;  br_kind_o = BR_EQ;  end
          OP_BNE:  begin aluop_o = ALU_BNE;  br_kind_o = BR_NE;  end
          OP_BLT:  begin aluop_o = ALU_BLT;  br_kind_o = BR_LT;  end
          OP_BGE:  begin aluop_o = ALU_BGE;  br_kind_o = BR_GE;  end
          OP_BLTU: begin aluop_o = ALU_BLTU; br_kind_o = BR_LTU; end
          default: begin aluop_o = ALU_BGEU; br_kind_o = BR_GEU; end
        endcase
      end
      OP_MEM:
      begin
        valid_o     = 1'b1;
        alusel_o    = SEL_LOAD_STORE;
        reg1_read_o = 1'b1;
        reg2_addr_o = rd;
        case (inst_i[25:22])
          4'b0000: begin aluop_o = ALU_LD_B;  wreg_o = 1'b1; end
          4'b0001: begin aluop_o = ALU_LD_H;  wreg_o = 1'b1; end
          4'b0010: begin aluop_o = ALU_LD_W;  wreg_o = 1'b1; end
          4'b1000: begin aluop_o = ALU_LD_BU; wreg_o = 1'b1; end
          4'b1001: begin aluop_o = ALU_LD_HU; wreg_o = 1'b1; end
          4'b0100: begin aluop_o = ALU_ST_B;  reg2_read_o = 1'b1; end
          4'b0101: begin aluop_o = ALU_ST_H;  reg2_read_o = 1'b1; end
          4'b0110: begin aluop_o = ALU_ST_W;  reg2_read_o = 1'b1; end
          default: valid_o = 1'b0;
        endcase
      end
      OP_ARITH:
      begin
        valid_o     = 1'b1;
        wreg_o      = 1'b1;
        reg1_read_o = 1'b1;
        casez (inst_i[25:20])
          6'b000001:
          begin
            // 3R group, function in [19:15]
            reg2_read_o = 1'b1;
            case (inst_i[19:15])
              5'b00000: begin aluop_o = ALU_ADD;  alusel_o = SEL_ARITH; end
              5'b00010: begin aluop_o = ALU_SUB;  alusel_o = SEL_ARITH; end
              5'b00100: begin aluop_o = ALU_SLT;  alusel_o = SEL_ARITH; end
              5'b00101: begin aluop_o = ALU_SLTU; alusel_o = SEL_ARITH; end
              5'b01000: begin aluop_o = ALU_NOR;  alusel_o = SEL_LOGIC; end
              5'b01001: begin aluop_o = ALU_AND;  alusel_o = SEL_LOGIC; end
              5'b01010: begin aluop_o = ALU_OR;   alusel_o = SEL_LOGIC; end
              5'b01011: begin aluop_o = ALU_XOR;  alusel_o = SEL_LOGIC; end
              5'b01110: begin aluop_o = ALU_SLL;  alusel_o = SEL_SHIFT; end
              5'b01111: begin aluop_o = ALU_SRL;  alusel_o = SEL_SHIFT; end
              5'b10000: begin aluop_o = ALU_SRA;  alusel_o = SEL_SHIFT; end
              default:  valid_o = 1'b0;
            endcase
          end
          6'b000100:
          begin
            alusel_o = SEL_SHIFT;
            imm_o    = {{(`ID_XLEN-5){1'b0}}, inst_i[14:10]};
            case (inst_i[19:15])
              5'b00001: aluop_o = ALU_SLL;
              5'b01001: aluop_o = ALU_SRL;
              5'b10001: aluop_o = ALU_SRA;
              default:  valid_o = 1'b0;
            endcase
          end
          6'b1?????:
          begin
            // 12-bit immediates, zero-extended
            imm_o = {{(`ID_XLEN-12){1'b0}}, inst_i[21:10]};
            case (inst_i[25:22])
              4'b1000: begin aluop_o = ALU_SLT;  alusel_o = SEL_ARITH; end
              4'b1001: begin aluop_o = ALU_SLTU; alusel_o = SEL_ARITH; end
              4'b1010: begin aluop_o = ALU_ADD;  alusel_o = SEL_ARITH; end
              4'b1101: begin aluop_o = ALU_AND;  alusel_o = SEL_LOGIC; end
              4'b1110: begin aluop_o = ALU_OR;   alusel_o = SEL_LOGIC; end
              4'b1111: begin aluop_o = ALU_XOR;  alusel_o = SEL_LOGIC; end
              default: valid_o = 1'b0;
            endcase
          end
          default: valid_o = 1'b0;
        endcase
      end
      default:
      begin
        if (inst_i[31:25] == OP7_LU12I || inst_i[31:25] == OP7_PCADDU12I)
        begin
          valid_o  = 1'b1;
          wreg_o   = 1'b1;
          alusel_o = SEL_MOVE;
          imm_o    = imm_u20;
          aluop_o  = (inst_i[31:25] == OP7_LU12I) ? ALU_LUI : ALU_PCADD;
        end
      end
    endcase

    // Unknown encodings leave no side effects
    if (!valid_o)
    begin
      reg1_read_o = 1'b0;
      reg2_read_o = 1'b0;
      wreg_o      = 1'b0;
      imm_o       = '0;
      aluop_o     = ALU_NOP;
      alusel_o    = SEL_NOP;
      br_kind_o   = BR_NONE;
    end
  end

  // Stores write no register, so only loads count
  assign ex_is_load = ex_aluop_i inside {ALU_LD_B, ALU_LD_H, ALU_LD_W, ALU_LD_BU, ALU_LD_HU};

  assign stall_o = ex_is_load &&
                   ((reg1_read_o && ex_waddr_i == reg1_addr_o) ||
                    (reg2_read_o && ex_waddr_i == reg2_addr_o));

endmodule

`default_nettype wire

// File: rtl/id_pkg.sv
`default_nettype none

`include "id_cfg.svh"

package id_pkg;

  typedef logic [`ID_XLEN-1:0] word_t;
  typedef logic [`ID_REG_AW-1:0] reg_addr_t;

  // Major groups from inst[31:26]
  typedef enum logic [5:0] {
    OP_ARITH = 6'b000000,
    OP_MEM   = 6'b001010,
    OP_JIRL  = 6'b010011,
    OP_B     = 6'b010100,
    OP_BL    = 6'b010101,
    OP_BEQ   = 6'b010110,
    OP_BNE   = 6'b010111,
    OP_BLT   = 6'b011000,
    OP_BGE   = 6'b011001,
    OP_BLTU  = 6'b011010,
    OP_BGEU  = 6'b011011
  } major_op_e;

  // NOP must stay at zero, a bubble is all zeros
  typedef enum logic [4:0] {
    ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
    ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_LUI, ALU_PCADD,
    ALU_LD_B, ALU_LD_H, ALU_LD_W, ALU_LD_BU, ALU_LD_HU,
    ALU_ST_B, ALU_ST_H, ALU_ST_W,
    ALU_JIRL, ALU_B, ALU_BL,
    ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
  } alu_op_e;

  typedef enum logic [2:0] {
    SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_ARITH, SEL_MOVE, SEL_LOAD_STORE, SEL_JUMP
  } alu_sel_e;

  typedef enum logic [3:0] {
    BR_NONE, BR_JIRL, BR_B, BR_BL, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
  } br_kind_e;

  // Pending write of a later stage
  typedef struct packed {
    logic      wreg;
    reg_addr_t waddr;
    word_t     wdata;
  } wb_fwd_t;

  typedef struct packed {
    logic      valid;
    alu_op_e   aluop;
    alu_sel_e  alusel;
    word_t     op1;
    word_t     op2;
    reg_addr_t waddr;
    logic      wreg;
    word_t     pc;
    word_t     inst;
  } ex_bundle_t;

  typedef struct packed {
    logic  taken;
    word_t target;
    word_t link;
  } branch_t;

endpackage

`default_nettype wire

// File: rtl/id_cfg.svh
`ifndef ID_CFG_SVH
`define ID_CFG_SVH

// Data and address width
`define ID_XLEN 32

// Register file index width
`define ID_REG_AW 5

// BL writes its return address here
`define ID_LINK_REG 1

`define ID_PC_STEP 4

`endif
